/* logic/uart_pkg.sv */
// UART shared definitions
package uart_pkg;

    localparam int DATA_BITS     = 8;
    localparam int OVERSAMPLE    = 16;   // ticks per bit
    localparam int DIV_W         = 11;
    localparam int TX_FIFO_DEPTH = 4;    // also the initial host credits
    localparam int CREDIT_W      = 3;

    localparam logic [DIV_W-1:0] DIV_RESET = DIV_W'(325); // 9600 baud at 50 MHz

    localparam int FRAME_BITS = DATA_BITS + 2;              // start + data + stop
    localparam int FRAME_W    = $clog2(FRAME_BITS);         // bit index within a frame
    localparam int CNT_W      = $clog2(OVERSAMPLE + 1);     // tick and sample counters
    localparam int PTR_W      = $clog2(TX_FIFO_DEPTH);

    // control register bit positions
    localparam int CTRL_TX_BIT = 0;
    localparam int CTRL_RX_BIT = 1;

    typedef enum logic {
        CFG_DIVISOR = 1'b0,
        CFG_CTRL    = 1'b1
    } cfg_addr_e;

    typedef struct packed {
        logic             valid;
        cfg_addr_e        addr;
        logic [DIV_W-1:0] data;
    } cfg_wr_t;

    typedef struct packed {
        logic [DIV_W-1:0] divisor;
        logic             tx_enable;
        logic             rx_enable;
    } cfg_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    typedef enum logic {
        TX_IDLE,
        TX_SHIFT
    } tx_state_e;

    typedef struct packed {
        logic                 valid;
        logic [DATA_BITS-1:0] data;
        logic                 frame_err;
    } rx_byte_t;

    typedef struct packed {
        logic                 valid;
        logic [DATA_BITS-1:0] data;
    } tx_push_t;

endpackage

/* logic/uart_cfg_regs.sv */
// UART configuration registers
`timescale 1ns/1ps

module uart_cfg_regs (
    input  logic              clk,
    input  logic              reset_i,
    input  uart_pkg::cfg_wr_t cfg_wr_i,
    output uart_pkg::cfg_t    cfg_o,
    output logic              div_load_o
);
    import uart_pkg::*;

    cfg_t cfg_q;
    logic div_load_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cfg_q.divisor   <= DIV_RESET;
            cfg_q.tx_enable <= 1'b1;
            cfg_q.rx_enable <= 1'b1;
        end else if (cfg_wr_i.valid) begin
            case (cfg_wr_i.addr)
                CFG_DIVISOR: begin
                    cfg_q.divisor <= cfg_wr_i.data;
                end
                CFG_CTRL: begin
                    cfg_q.tx_enable <= cfg_wr_i.data[CTRL_TX_BIT];
                    cfg_q.rx_enable <= cfg_wr_i.data[CTRL_RX_BIT];
                end
                default: begin
                    cfg_q <= cfg_q;
                end
            endcase
        end
    end

    // restart pulse lines up with the new divisor value
    always_ff @(posedge clk) begin
        if (reset_i) begin
            div_load_q <= 1'b0;
        end else begin
            div_load_q <= cfg_wr_i.valid && (cfg_wr_i.addr == CFG_DIVISOR);
        end
    end

    assign cfg_o      = cfg_q;
    assign div_load_o = div_load_q;

endmodule

/* logic/uart_baud_gen.sv */
// UART baud tick generator
`timescale 1ns/1ps

module uart_baud_gen (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic [uart_pkg::DIV_W-1:0] divisor_i,
    input  logic                       div_load_i,
    output logic                       tick_o
);
    import uart_pkg::*;

    logic [DIV_W-1:0] cnt_q;
    logic             at_zero;

    assign at_zero = (cnt_q == '0);

    // period is divisor + 1 cycles
    always_ff @(posedge clk) begin
        if (reset_i) begin
            cnt_q <= '0;
        end else if (div_load_i || at_zero) begin
            cnt_q <= divisor_i;
        end else begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    assign tick_o = at_zero; // 16x oversampling strobe

endmodule

/* logic/uart_rx.sv */
// UART serial receiver
`timescale 1ns/1ps

module uart_rx (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               tick_i,
    input  logic               rx_enable_i,
    input  logic               rx_i,
    output uart_pkg::rx_byte_t rx_o
);
    import uart_pkg::*;

    logic [1:0]           sync_q;
    logic                 line_prev_q;
    logic [CNT_W-1:0]     tick_cnt_q;
    logic [CNT_W-1:0]     high_cnt_q;
    logic [FRAME_W-1:0]   bit_idx_q;
    logic [DATA_BITS-1:0] shift_q;
    logic                 valid_q;
    logic                 ferr_q;
    rx_state_e            state_q;

    logic line;
    logic edge_seen;
    logic fall;
    logic bit_done;
    logic bit_val;

    assign line      = sync_q[1];
    assign edge_seen = line ^ line_prev_q;
    assign fall      = edge_seen && !line;

    // a late edge closes the bit, an early one only re-aligns
    assign bit_done = (tick_cnt_q == CNT_W'(OVERSAMPLE))
                   || (edge_seen && (tick_cnt_q >= CNT_W'(OVERSAMPLE / 2)));
    assign bit_val  = high_cnt_q > CNT_W'(OVERSAMPLE / 2); // majority vote

    always_ff @(posedge clk) begin
        if (reset_i) begin
            sync_q      <= 2'b11; // idle line is high
            line_prev_q <= 1'b1;
        end else begin
            sync_q      <= {sync_q[0], rx_i};
            line_prev_q <= line;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || state_q == RX_IDLE || bit_done || edge_seen) begin
            tick_cnt_q <= '0;
            high_cnt_q <= '0;
        end else if (tick_i) begin
            tick_cnt_q <= tick_cnt_q + 1'b1;
            high_cnt_q <= high_cnt_q + CNT_W'(line);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q   <= RX_IDLE;
            bit_idx_q <= '0;
            valid_q   <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            if (!rx_enable_i) begin
                state_q <= RX_IDLE;
            end else begin
                unique case (state_q)
                    RX_IDLE: begin
                        if (fall) begin
                            state_q   <= RX_DATA;
                            bit_idx_q <= '0;
                        end
                    end
                    RX_DATA: begin // index 0 is the start bit
                        if (bit_done) begin
                            if (bit_idx_q == '0 && bit_val) begin
                                state_q <= RX_IDLE; // glitch, not a start bit
                            end else if (bit_idx_q == FRAME_W'(DATA_BITS)) begin
                                state_q <= RX_STOP;
                            end
                            bit_idx_q <= bit_idx_q + 1'b1;
                        end
                    end
                    RX_STOP: begin
                        if (bit_done) begin
                            valid_q   <= 1'b1;
                            state_q   <= fall ? RX_DATA : RX_IDLE; // back-to-back start
                            bit_idx_q <= '0;
                        end
                    end
                    default: begin
                        state_q <= RX_IDLE;
                    end
                endcase
            end
        end
    end

    // start bit falls off the bottom after the eighth data bit
    always_ff @(posedge clk) begin
        if (state_q == RX_DATA && bit_done) begin
            shift_q <= {bit_val, shift_q[DATA_BITS-1:1]};
        end
        if (state_q == RX_STOP && bit_done) begin
            ferr_q <= !bit_val;
        end
    end

    always_comb begin
        rx_o.valid     = valid_q;
        rx_o.data      = shift_q;
        rx_o.frame_err = ferr_q;
    end

endmodule

/* logic/uart_tx_fifo.sv */
// UART transmit FIFO
`timescale 1ns/1ps

module uart_tx_fifo (
    input  logic                           clk,
    input  logic                           reset_i,
    input  uart_pkg::tx_push_t             push_i,
    input  logic                           pop_i,
    output logic [uart_pkg::DATA_BITS-1:0] head_o,
    output logic                           nonempty_o,
    output logic                           credit_o
);
    import uart_pkg::*;

    logic [DATA_BITS-1:0] mem_q [TX_FIFO_DEPTH];
    logic [PTR_W-1:0]     wr_ptr_q;
    logic [PTR_W-1:0]     rd_ptr_q;
    logic [CREDIT_W-1:0]  count_q;

    logic full;
    logic push_ok;
    logic pop_ok;

    assign full       = (count_q == CREDIT_W'(TX_FIFO_DEPTH));
    assign nonempty_o = (count_q != '0);
    assign push_ok    = push_i.valid && !full; // push without credit is dropped
    assign pop_ok     = pop_i && nonempty_o;

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem_q[wr_ptr_q] <= push_i.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(TX_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(TX_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    assign head_o   = mem_q[rd_ptr_q];
    assign credit_o = pop_ok; // one credit back per byte handed to the transmitter

endmodule

/* logic/uart_tx.sv */
// UART serial transmitter
`timescale 1ns/1ps

module uart_tx (
    input  logic                           clk,
    input  logic                           reset_i,
    input  logic                           tick_i,
    input  logic                           tx_enable_i,
    input  logic [uart_pkg::DATA_BITS-1:0] data_i,
    input  logic                           nonempty_i,
    output logic                           pop_o,
    output logic                           tx_o
);
    import uart_pkg::*;

    tx_state_e             state_q;
    logic [CNT_W-1:0]      tick_cnt_q;
    logic [FRAME_W-1:0]    bit_cnt_q;
    logic [FRAME_BITS-1:0] frame_q;
    logic                  line_q;

    logic ready;
    logic bit_tick;

    assign ready    = (state_q == TX_IDLE) && tx_enable_i;
    assign pop_o    = ready && nonempty_i;
    assign bit_tick = tick_i && (tick_cnt_q == CNT_W'(OVERSAMPLE - 1));

    // free running, so bit boundaries never move
    always_ff @(posedge clk) begin
        if (reset_i) begin
            tick_cnt_q <= '0;
        end else if (tick_i) begin
            tick_cnt_q <= (tick_cnt_q == CNT_W'(OVERSAMPLE - 1)) ? '0 : tick_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q   <= TX_IDLE;
            bit_cnt_q <= '0;
            line_q    <= 1'b1;
        end else begin
            unique case (state_q)
                TX_IDLE: begin
                    if (pop_o) begin
                        state_q   <= TX_SHIFT;
                        bit_cnt_q <= '0;
                    end
                end
                TX_SHIFT: begin
                    if (bit_tick) begin
                        line_q    <= frame_q[0];
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        // stop bit now on the line, held until the next boundary
                        if (bit_cnt_q == FRAME_W'(FRAME_BITS - 1)) begin
                            state_q <= TX_IDLE;
                        end
                    end
                end
                default: begin
                    state_q <= TX_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop_o) begin
            frame_q <= {1'b1, data_i, 1'b0}; // stop, data, start
        end else if (state_q == TX_SHIFT && bit_tick) begin
            frame_q <= {1'b1, frame_q[FRAME_BITS-1:1]};
        end
    end

    assign tx_o = line_q;

endmodule

/* logic/uart_top.sv */
// UART subsystem top level
`timescale 1ns/1ps

module uart_top (
    input  logic               clk,
    input  logic               reset_i,
    input  uart_pkg::cfg_wr_t  cfg_wr_i,
    input  uart_pkg::tx_push_t tx_push_i,
    input  logic               rx_i,
    output logic               tx_o,
    output logic               tx_credit_o,
    output uart_pkg::rx_byte_t rx_o
);
    import uart_pkg::*;

    cfg_t                 cfg;
    logic                 div_load;
    logic                 tick;
    logic                 pop;
    logic                 nonempty;
    logic [DATA_BITS-1:0] head;

    uart_cfg_regs u_cfg_regs (
        .clk        (clk),
        .reset_i    (reset_i),
        .cfg_wr_i   (cfg_wr_i),
        .cfg_o      (cfg),
        .div_load_o (div_load)
    );

    uart_baud_gen u_baud_gen (
        .clk        (clk),
        .reset_i    (reset_i),
        .divisor_i  (cfg.divisor),
        .div_load_i (div_load),
        .tick_o     (tick)
    );

    uart_rx u_rx (
        .clk         (clk),
        .reset_i     (reset_i),
        .tick_i      (tick),
        .rx_enable_i (cfg.rx_enable),
        .rx_i        (rx_i),
        .rx_o        (rx_o)
    );

    uart_tx_fifo u_tx_fifo (
        .clk        (clk),
        .reset_i    (reset_i),
        .push_i     (tx_push_i),
        .pop_i      (pop),
        .head_o     (head),
        .nonempty_o (nonempty),
        .credit_o   (tx_credit_o)
    );

    uart_tx u_tx (
        .clk         (clk),
        .reset_i     (reset_i),
        .tick_i      (tick),
        .tx_enable_i (cfg.tx_enable),
        .data_i      (head),
        .nonempty_i  (nonempty),
        .pop_o       (pop),
        .tx_o        (tx_o)
    );

endmodule

/* testbench/uart_tb.sv */
// UART subsystem testbench
`timescale 1ns/1ps

module uart_tb;
    import uart_pkg::*;

    localparam int WAIT_BITS = 120; // bit times any wait may take

    logic       clk = 1'b0;
    logic       reset_i;
    cfg_wr_t    cfg_wr_i;
    tx_push_t   tx_push_i;
    logic       rx_i = 1'b1;
    logic       tx_o;
    logic       tx_credit_o;
    rx_byte_t   rx_o;

    logic       loop_on = 1'b0;
    logic       inj_line = 1'b1;
    logic       tx_enabled = 1'b1;
    int         bit_cycles = OVERSAMPLE * (int'(DIV_RESET) + 1);
    int         pushes_sent = 0;
    int         credits_back = 0;
    logic [7:0] tx_exp[$];
    logic [8:0] rx_exp[$]; // {data, frame_err}
    logic [8:0] rx_got[$];

    uart_top DUT (
        .clk         (clk),
        .reset_i     (reset_i),
        .cfg_wr_i    (cfg_wr_i),
        .tx_push_i   (tx_push_i),
        .rx_i        (rx_i),
        .tx_o        (tx_o),
        .tx_credit_o (tx_credit_o),
        .rx_o        (rx_o)
    );

    always #50 clk = ~clk;

    always @(negedge clk) rx_i <= loop_on ? tx_o : inj_line; // loopback mux

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    always @(negedge clk) begin
        if (!reset_i && tx_credit_o) begin
            assert (credits_back < pushes_sent) else stop_on_error($sformatf(
                "ERROR %0t: tx_credit_o count expected <= %0d got %0d",
                $time, pushes_sent, credits_back + 1));
            credits_back <= credits_back + 1;
        end
    end

    always @(negedge clk) begin : rx_check
        logic [8:0] got;
        logic [8:0] want;
        if (!reset_i && rx_o.valid) rx_got.push_back({rx_o.data, rx_o.frame_err});
        if (rx_got.size() > 0 && rx_exp.size() > 0) begin
            got  = rx_got.pop_front();
            want = rx_exp.pop_front();
            assert (got == want) else stop_on_error($sformatf(
                "ERROR %0t: rx_o data/frame_err expected %h/%b got %h/%b",
                $time, want[8:1], want[0], got[8:1], got[0]));
        end
    end

    // edges only on bit boundaries, bits sampled mid-bit
    task automatic decode_frame();
        int         period;
        int         n;
        logic       prev;
        logic [7:0] bits;
        period = bit_cycles;
        prev   = 1'b0;
        bits   = '0;
        for (n = 1; n <= 9 * period + period / 2; n++) begin
            @(negedge clk);
            assert (tx_o === prev || n % period == 0) else stop_on_error($sformatf(
                "ERROR %0t: tx_o edge offset expected multiple of %0d got %0d",
                $time, period, n));
            prev = tx_o;
            if (n % period == period / 2 && n / period == 0) begin
                assert (tx_o === 1'b0) else stop_on_error($sformatf(
                    "ERROR %0t: tx_o start bit expected 0 got %b", $time, tx_o));
            end else if (n % period == period / 2 && n / period <= DATA_BITS) begin
                bits[n / period - 1] = tx_o;
            end else if (n % period == period / 2) begin
                assert (tx_o === 1'b1) else stop_on_error($sformatf(
                    "ERROR %0t: tx_o stop bit expected 1 got %b", $time, tx_o));
            end
        end
        assert (tx_exp.size() > 0) else stop_on_error("a frame appeared on tx_o with no byte pending");
        assert (bits == tx_exp[0]) else stop_on_error($sformatf(
            "ERROR %0t: tx_o data expected %h got %h", $time, tx_exp[0], bits));
        void'(tx_exp.pop_front());
    endtask

    initial begin : tx_decoder
        logic tx_prev;
        tx_prev = 1'b1;
        forever begin
            @(negedge clk);
            if (!reset_i && tx_prev && !tx_o) decode_frame();
            tx_prev = tx_o;
        end
    end

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (tx_exp.size() != 0 || rx_exp.size() != 0 || rx_got.size() != 0) begin
            @(negedge clk);
            waited++;
            assert (waited < WAIT_BITS * bit_cycles) else stop_on_error($sformatf(
                "timeout waiting to drain: %0d tx frames, %0d rx expected, %0d rx unmatched",
                tx_exp.size(), rx_exp.size(), rx_got.size()));
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        int waited;
        waited = 0;
        while (pushes_sent - credits_back >= TX_FIFO_DEPTH) begin
            @(negedge clk);
            waited++;
            assert (waited < WAIT_BITS * bit_cycles)
                else stop_on_error("timeout waiting for a transmit credit");
        end
        tx_push_i = '{valid: 1'b1, data: b};
        pushes_sent++;
        tx_exp.push_back(b);
        if (loop_on) rx_exp.push_back({b, 1'b0});
        @(negedge clk);
        tx_push_i.valid = 1'b0;
    endtask

    task automatic inject_frame(input logic [7:0] b, input logic stop);
        logic [FRAME_BITS-1:0] frame;
        int                    i;
        frame = {stop, b, 1'b0};
        for (i = 0; i < FRAME_BITS; i++) begin
            inj_line <= frame[i];
            repeat (bit_cycles) @(negedge clk);
        end
        inj_line <= 1'b1;
        repeat (2 * bit_cycles) @(negedge clk); // idle gap before next start
    endtask

    task automatic write_cfg(input int addr, input int value);
        int n;
        if (tx_enabled) wait_drained();
        for (n = 0; !tx_enabled && n < 2 * FRAME_BITS * bit_cycles; n++) begin
            @(negedge clk);
            assert (tx_o === 1'b1 && tx_credit_o === 1'b0) else stop_on_error($sformatf(
                "ERROR %0t: tx_o/tx_credit_o with tx disabled expected 1/0 got %b/%b",
                $time, tx_o, tx_credit_o));
        end
        cfg_wr_i = '{valid: 1'b1, addr: cfg_addr_e'(addr), data: DIV_W'(value)};
        @(negedge clk);
        cfg_wr_i.valid = 1'b0;
        if (cfg_addr_e'(addr) == CFG_DIVISOR) bit_cycles = OVERSAMPLE * (value + 1);
        else tx_enabled = value[CTRL_TX_BIT];
    endtask

    initial begin : main
        int    fd;
        int    n;
        int    a;
        int    v;
        string cmd;
        string rest;
        reset_i   = 1'b1;
        cfg_wr_i  = '0;
        tx_push_i = '0;
        repeat (3) @(negedge clk);
        reset_i = 1'b0;
        for (n = 0; n < 16; n++) begin
            @(negedge clk);
            assert (tx_o === 1'b1 && rx_o.valid === 1'b0 && tx_credit_o === 1'b0)
                else stop_on_error($sformatf(
                    "ERROR %0t: tx_o/rx_o.valid/tx_credit_o expected 1/0/0 got %b/%b/%b",
                    $time, tx_o, rx_o.valid, tx_credit_o));
        end
        fd = $fopen("testbench/uart_trace.txt", "r");
        assert (fd != 0) else stop_on_error("could not open testbench/uart_trace.txt");
        while ($fscanf(fd, "%s", cmd) == 1) begin
            if (cmd.substr(0, 0) == "#") begin
                n = $fgets(rest, fd);
            end else if (cmd == "send" || cmd == "loop") begin
                n = $fscanf(fd, "%h", v);
                assert (n == 1) else stop_on_error({"malformed trace line for ", cmd});
                if (cmd == "send") begin
                    send_byte(8'(v));
                end else begin
                    wait_drained();
                    loop_on = (v != 0);
                end
            end else begin
                n = $fscanf(fd, "%h %h", a, v);
                assert (n == 2) else stop_on_error({"malformed trace line for ", cmd});
                case (cmd)
                    "cfg":       write_cfg(a, v);
                    "inject":    inject_frame(8'(a), v[0]);
                    "expect_rx": rx_exp.push_back({8'(a), v[0]});
                    default:     stop_on_error({"unknown trace command ", cmd});
                endcase
            end
        end
        $fclose(fd);
        wait_drained();
        assert (credits_back == pushes_sent) begin
            $display("TEST OK");
            $finish;
        end else begin
            stop_on_error($sformatf("ERROR %0t: tx_credit_o pulses expected %0d got %0d",
                $time, pushes_sent, credits_back));
        end
    end

endmodule

/* testbench/uart_trace.txt */
# command and hex values: cfg <addr> <data>, send <byte>, loop <on>
# inject <byte> <stop bit>, expect_rx <byte> <frame_err>
cfg 0 003
send a5
send 3c
send ff
send 00
send 81
send 5a
loop 1
send 12
send 34
send 56
send 78
send 9a
loop 0
inject c3 1
expect_rx c3 0
inject 7e 0
expect_rx 7e 1
inject 55 1
expect_rx 55 0
cfg 0 007
send e7
send 18
loop 1
send 69
loop 0
cfg 1 002
send 42
cfg 1 003
send 99

/* vlog.f */
logic/uart_pkg.sv
logic/uart_cfg_regs.sv
logic/uart_baud_gen.sv
logic/uart_rx.sv
logic/uart_tx_fifo.sv
logic/uart_tx.sv
logic/uart_top.sv
testbench/uart_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module uart_tb -f vlog.f -o uart_sim
	./obj_dir/uart_sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^TEST OK" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
